//--- mini6502Core.f
+incdir+include
hdl/mini6502Pkg.sv
hdl/fetchPredecode.sv
hdl/instrQueue.sv
hdl/executeUnit.sv
hdl/mini6502Core.sv
verification/mini6502_assertions.sv
verification/mini6502Tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mini6502Tb
FILELIST  ?= mini6502Core.f
OBJDIR    ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# output goes to the terminal, the grep status decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- verification/mini6502Tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM holds up to 1024 program bytes from RESET_PC
// bytes past the loaded program read as NOP
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "mini6502_settings.svh"

module mini6502Tb
  import mini6502Pkg::*;
();

  logic        phi2;
  logic        rst;
  logic        rdy;
  logic [7:0]  progData;
  logic [15:0] progAddr;
  logic        sync;
  logic        wrStrobe;
  logic [7:0]  wrAddr;
  logic [7:0]  wrData;
  logic [7:0]  status;

  logic [7:0]  rom [0:1023];
  logic [7:0]  prog [$];
  int          progLen;
  logic [15:0] romOffset;
  logic [31:0] rngState;
  int          mismatchCount;
  int          otherCount;
  // stores as {addr, data, status}
  logic [23:0] expStores [$];
  logic [23:0] actStores [$];

  mini6502Core dut0 (
    .phi2(phi2), .rst(rst), .progData(progData), .rdy(rdy), .progAddr(progAddr),
    .sync(sync), .wrStrobe(wrStrobe), .wrAddr(wrAddr), .wrData(wrData), .status(status)
  );

  initial begin
    phi2 = 1'b0;
    forever #4 phi2 = ~phi2;
  end

  assign romOffset = progAddr - `RESET_PC;
  assign progData  = (romOffset < progLen) ? rom[romOffset[9:0]] : 8'hEA;

  // strobe and status are settled at mid-cycle
  always @(negedge phi2) begin
    if (wrStrobe) begin
      actStores.push_back({wrAddr, wrData, status});
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    return r ^ (r << 5);
  endfunction

  function automatic logic [7:0] withNz(input logic [7:0] st, input logic [7:0] val);
    logic [7:0] r;
    r              = st;
    r[zeroBit]     = (val == 8'h00);
    r[negativeBit] = val[7];
    return r;
  endfunction

  // reference model walks the ROM and lists the expected stores
  task automatic buildExpected();
    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] st;
    logic [7:0] op;
    logic [7:0] opd;
    logic [8:0] uSum;
    int         sSum;
    int         pos;
    a   = 8'h00;
    x   = 8'h00;
    st  = 8'h20;
    pos = 0;
    expStores.delete();
    while (pos < progLen) begin
      op  = rom[pos];
      opd = (pos + 1 < progLen) ? rom[pos + 1] : 8'hEA;
      pos = pos + 2;
      case (op)
        LDA_IMM: a = opd;
        LDX_IMM: x = opd;
        AND_IMM: a = a & opd;
        ORA_IMM: a = a | opd;
        EOR_IMM: a = a ^ opd;
        ADC_IMM: begin
          uSum = {1'b0, a} + {1'b0, opd} + 9'(st[carryBit]);
          sSum = int'($signed(a)) + int'($signed(opd)) + int'(st[carryBit]);
          a    = uSum[7:0];
          st[carryBit]    = uSum[8];
          st[overflowBit] = (sSum > 127) || (sSum < -128);
        end
        STA_ZP: expStores.push_back({opd, a, st});
        STX_ZP: expStores.push_back({opd, x, st});
        default: begin
          // one-byte forms and unknown bytes
          pos = pos - 1;
          case (op)
            TAX: x = a;
            INX: x = x + 8'd1;
            CLC: st[carryBit] = 1'b0;
            SEC: st[carryBit] = 1'b1;
            default: ;
          endcase
        end
      endcase
      if (op inside {LDA_IMM, AND_IMM, ORA_IMM, EOR_IMM, ADC_IMM}) begin
        st = withNz(st, a);
      end
      if (op inside {LDX_IMM, TAX, INX}) begin
        st = withNz(st, x);
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      mismatchCount++;
    end
  endtask

  // loads prog under reset and returns at the falling edge that releases rst
  task automatic startProgram();
    @(negedge phi2);
    rst     = 1'b1;
    rdy     = 1'b1;
    progLen = prog.size();
    foreach (prog[i]) begin
      rom[i] = prog[i];
    end
    buildExpected();
    repeat (3) @(negedge phi2);
    actStores.delete();
    rst = 1'b0;
  endtask

  task automatic finishProgram(input string name, input bit stallRandomly);
    int cycles;
    cycles = 0;
    while (actStores.size() < expStores.size() && cycles < 5000) begin
      @(negedge phi2);
      cycles++;
      if (stallRandomly) begin
        rngState = xorshift32(rngState);
        rdy      = rngState[3] | rngState[9];
      end
    end
    rdy = 1'b1;
    if (actStores.size() < expStores.size()) begin
      $display("%s: timed out after %0d cycles with %0d of %0d stores seen", name, cycles,
               actStores.size(), expStores.size());
      otherCount++;
    end
    // spare cycles catch stray stores
    repeat (12) @(negedge phi2);
    assert (actStores.size() == expStores.size()) else begin
      $display("MISMATCH %s store count expected %0d actual %0d", name,
               expStores.size(), actStores.size());
      mismatchCount++;
    end
    foreach (expStores[i]) begin
      if (i < actStores.size()) begin
        assert (actStores[i] == expStores[i]) else begin
          $display("MISMATCH %s store %0d addr/data/status expected %h actual %h", name, i,
                   expStores[i], actStores[i]);
          mismatchCount++;
        end
      end
    end
  endtask

  task automatic resetThenStoreZeros();
    prog = {STA_ZP, 8'h00, STX_ZP, 8'h01};
    startProgram();
    checkValue("reset wrStrobe", 16'h0000, 16'(wrStrobe));
    checkValue("reset status", 16'h0020, 16'(status));
    checkValue("reset sync", 16'h0001, 16'(sync));
    checkValue("reset progAddr", `RESET_PC, progAddr);
    finishProgram("reset", 1'b0);
  endtask

  task automatic loadStoreTransfer();
    prog = {LDA_IMM, 8'h80, STA_ZP, 8'h10, LDX_IMM, 8'h00, STX_ZP, 8'h11,
            LDA_IMM, 8'hFF, TAX, STX_ZP, 8'h12, INX, STX_ZP, 8'h13,
            LDA_IMM, 8'h7F, TAX, INX, STX_ZP, 8'h14, STA_ZP, 8'h15};
    startProgram();
    finishProgram("loadStore", 1'b0);
  endtask

  task automatic adcCarryOverflow();
    prog = {CLC, LDA_IMM, 8'h7F, ADC_IMM, 8'h01, STA_ZP, 8'h20,
            CLC, LDA_IMM, 8'hFF, ADC_IMM, 8'h01, STA_ZP, 8'h21,
            SEC, LDA_IMM, 8'h10, ADC_IMM, 8'h20, STA_ZP, 8'h22,
            SEC, LDA_IMM, 8'h80, ADC_IMM, 8'h80, STA_ZP, 8'h23};
    startProgram();
    finishProgram("arith", 1'b0);
  endtask

  task automatic logicAndUnknownOps();
    // 02, FF and 44 are not in the subset
    prog = {LDA_IMM, 8'hF0, AND_IMM, 8'h3C, STA_ZP, 8'h30, 8'h02,
            ORA_IMM, 8'h0F, STA_ZP, 8'h31, 8'hFF, EOR_IMM, 8'hFF, STA_ZP, 8'h32,
            8'h44, LDA_IMM, 8'h55, AND_IMM, 8'hAA, STA_ZP, 8'h33};
    startProgram();
    finishProgram("logic", 1'b0);
  endtask

  task automatic stallWithRdyLow();
    int          cycles;
    logic [15:0] heldAddr;
    prog.delete();
    for (int i = 0; i < 12; i++) begin
      prog = {prog, LDA_IMM, 8'(i * 17), STA_ZP, 8'(i), INX, STX_ZP, 8'(i + 64)};
    end
    startProgram();
    cycles = 0;
    while (!wrStrobe && cycles < 200) begin
      @(negedge phi2);
      cycles++;
    end
    if (!wrStrobe) begin
      $display("backpressure: no store seen before the stall");
      otherCount++;
    end
    rdy = 1'b0;
    for (int i = 1; i <= 20; i++) begin
      @(negedge phi2);
      assert (!wrStrobe) else begin
        $display("backpressure: store strobe appeared while rdy was low");
        otherCount++;
      end
      if (i == 10) begin
        heldAddr = progAddr;
      end
    end
    checkValue("backpressure progAddr held", heldAddr, progAddr);
    rdy = 1'b1;
    finishProgram("backpressure", 1'b0);
  endtask

  task automatic randomProgram();
    logic [7:0] choices [13];
    logic [7:0] pick;
    choices = '{LDA_IMM, LDX_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM, TAX, INX,
                CLC, SEC, STA_ZP, STX_ZP, NOP};
    prog.delete();
    for (int i = 0; i < 200; i++) begin
      rngState = xorshift32(rngState);
      pick     = choices[rngState % 13];
      prog.push_back(pick);
      if (pick inside {LDA_IMM, LDX_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM,
                       STA_ZP, STX_ZP}) begin
        prog.push_back(rngState[23:16]);
      end
    end
    startProgram();
    finishProgram("random", 1'b1);
  endtask

  initial begin
    rst           = 1'b1;
    rdy           = 1'b1;
    progLen       = 0;
    rngState      = 32'd50;
    mismatchCount = 0;
    otherCount    = 0;
    resetThenStoreZeros();
    loadStoreTransfer();
    adcCarryOverflow();
    logicAndUnknownOps();
    stallWithRdyLow();
    randomProgram();
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/mini6502_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound twice, ports a unit lacks are tied inactive
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module mini6502Assertions (
  input logic phi2,
  input logic rst,
  input logic push,
  input logic notFull,
  input logic pop,
  input logic notEmpty,
  input logic rdy,
  input logic wrStrobe
);

  noPushWhenFull: assert property (@(posedge phi2) disable iff (rst) push |-> notFull)
    else $error("queue push while full");

  noPopWhenEmpty: assert property (@(posedge phi2) disable iff (rst) pop |-> notEmpty)
    else $error("queue pop while empty");

  noPopWhenStalled: assert property (@(posedge phi2) disable iff (rst) pop |-> rdy)
    else $error("pop while rdy low");

  // each store strobe stands alone
  singleStrobe: assert property (@(posedge phi2) disable iff (rst) wrStrobe |=> !wrStrobe)
    else $error("wrStrobe high two cycles in a row");

endmodule

// queue side has no rdy or store strobe
bind instrQueue mini6502Assertions queueChecks0 (
  .phi2(phi2), .rst(rst), .push(push), .notFull(notFull), .pop(pop),
  .notEmpty(notEmpty), .rdy(1'b1), .wrStrobe(1'b0)
);

// execute side never sees push
bind executeUnit mini6502Assertions execChecks0 (
  .phi2(phi2), .rst(rst), .push(1'b0), .notFull(1'b1), .pop(pop),
  .notEmpty(notEmpty), .rdy(rdy), .wrStrobe(wrStrobe)
);

`default_nettype wire

//--- hdl/mini6502Core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single clock phi2, store data valid with wrStrobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module mini6502Core
  import mini6502Pkg::*;
(
  input  logic        phi2,
  input  logic        rst,
  input  logic [7:0]  progData,
  input  logic        rdy,
  output logic [15:0] progAddr,
  output logic        sync,
  output logic        wrStrobe,
  output logic [7:0]  wrAddr,
  output logic [7:0]  wrData,
  output logic [7:0]  status
);

  // fetch to queue
  logic       push;
  opcodeT     pushOpcode;
  logic [7:0] pushOperand;
  logic       notFull;

  // queue to execute
  logic       pop;
  logic       notEmpty;
  opcodeT     headOpcode;
  logic [7:0] headOperand;

  fetchPredecode fetch0 (
    .phi2(phi2), .rst(rst), .progData(progData), .progAddr(progAddr), .sync(sync),
    .notFull(notFull), .push(push), .pushOpcode(pushOpcode), .pushOperand(pushOperand)
  );

  instrQueue queue0 (
    .phi2(phi2), .rst(rst), .push(push), .pushOpcode(pushOpcode),
    .pushOperand(pushOperand), .notFull(notFull), .pop(pop), .notEmpty(notEmpty),
    .headOpcode(headOpcode), .headOperand(headOperand)
  );

  executeUnit exec0 (
    .phi2(phi2), .rst(rst), .rdy(rdy), .notEmpty(notEmpty), .headOpcode(headOpcode),
    .headOperand(headOperand), .pop(pop), .wrStrobe(wrStrobe), .wrAddr(wrAddr),
    .wrData(wrData), .status(status)
  );

endmodule

`default_nettype wire

//--- hdl/executeUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// binary ADC only, no decimal mode
// back-to-back stores are spaced one cycle apart
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module executeUnit
  import mini6502Pkg::*;
(
  input  logic       phi2,
  input  logic       rst,
  input  logic       rdy,
  input  logic       notEmpty,
  input  opcodeT     headOpcode,
  input  logic [7:0] headOperand,
  output logic       pop,
  output logic       wrStrobe,
  output logic [7:0] wrAddr,
  output logic [7:0] wrData,
  output logic [7:0] status
);

  logic [7:0] accA;
  logic [7:0] regX;
  logic       flagC;
  logic       flagZ;
  logic       flagV;
  logic       flagN;

  logic       isStore;
  logic [8:0] sum;
  logic [7:0] nextA;
  logic [7:0] nextX;
  logic       nextC;
  logic       nextV;
  logic [7:0] nzValue;
  logic       updateNz;

  assign isStore = (headOpcode == STA_ZP) || (headOpcode == STX_ZP);

  // a store behind a store waits so each strobe stands alone
  assign pop = notEmpty && rdy && !(wrStrobe && isStore);

  // ALU and register next values for the head entry
  always_comb begin
    sum      = {1'b0, accA} + {1'b0, headOperand} + {8'd0, flagC};
    nextA    = accA;
    nextX    = regX;
    nextC    = flagC;
    nextV    = flagV;
    nzValue  = 8'h00;
    updateNz = 1'b0;
    case (headOpcode)
      LDA_IMM: begin
        nextA    = headOperand;
        nzValue  = headOperand;
        updateNz = 1'b1;
      end
      LDX_IMM: begin
        nextX    = headOperand;
        nzValue  = headOperand;
        updateNz = 1'b1;
      end
      ADC_IMM: begin
        nextA    = sum[7:0];
        nextC    = sum[8];
        // overflow when both inputs agree in sign and the sum does not
        nextV    = (accA[7] == headOperand[7]) && (sum[7] != accA[7]);
        nzValue  = sum[7:0];
        updateNz = 1'b1;
      end
      AND_IMM: begin
        nextA    = accA & headOperand;
        nzValue  = accA & headOperand;
        updateNz = 1'b1;
      end
      ORA_IMM: begin
        nextA    = accA | headOperand;
        nzValue  = accA | headOperand;
        updateNz = 1'b1;
      end
      EOR_IMM: begin
        nextA    = accA ^ headOperand;
        nzValue  = accA ^ headOperand;
        updateNz = 1'b1;
      end
      TAX: begin
        nextX    = accA;
        nzValue  = accA;
        updateNz = 1'b1;
      end
      INX: begin
        // wraps FF to 00
        nextX    = regX + 8'd1;
        nzValue  = regX + 8'd1;
        updateNz = 1'b1;
      end
      CLC: begin
        nextC = 1'b0;
      end
      SEC: begin
        nextC = 1'b1;
      end
      default: begin
        // NOP and stores leave registers alone
      end
    endcase
  end

  always_ff @(posedge phi2) begin
    if (rst) begin
      accA     <= 8'h00;
      regX     <= 8'h00;
      flagC    <= 1'b0;
      flagZ    <= 1'b0;
      flagV    <= 1'b0;
      flagN    <= 1'b0;
      wrStrobe <= 1'b0;
    end else begin
      wrStrobe <= pop && isStore;
      if (pop) begin
        accA  <= nextA;
        regX  <= nextX;
        flagC <= nextC;
        flagV <= nextV;
        if (updateNz) begin
          flagZ <= (nzValue == 8'h00);
          flagN <= nzValue[7];
        end
      end
    end
  end

  // store address and data, qualified by wrStrobe
  always_ff @(posedge phi2) begin
    if (pop && isStore) begin
      wrAddr <= headOperand;
      wrData <= (headOpcode == STA_ZP) ? accA : regX;
    end
  end

  always_comb begin
    status               = 8'h00;
    status[carryBit]     = flagC;
    status[zeroBit]      = flagZ;
    status[alwaysOneBit] = 1'b1;
    status[overflowBit]  = flagV;
    status[negativeBit]  = flagN;
  end

endmodule

`default_nettype wire

//--- hdl/instrQueue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// head outputs are the oldest entry, valid only while notEmpty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "mini6502_settings.svh"

module instrQueue
  import mini6502Pkg::*;
(
  input  logic       phi2,
  input  logic       rst,
  input  logic       push,
  input  opcodeT     pushOpcode,
  input  logic [7:0] pushOperand,
  output logic       notFull,
  input  logic       pop,
  output logic       notEmpty,
  output opcodeT     headOpcode,
  output logic [7:0] headOperand
);

  localparam int queueDepth = `QUEUE_DEPTH;
  localparam int ptrWidth   = $clog2(queueDepth);
  localparam int countWidth = $clog2(queueDepth + 1);

  opcodeT                opcodeMem [queueDepth];
  logic [7:0]            operandMem [queueDepth];
  logic [ptrWidth-1:0]   wrPtr;
  logic [ptrWidth-1:0]   rdPtr;
  logic [countWidth-1:0] count;
  logic                  doPush;
  logic                  doPop;

  assign notFull  = (count != countWidth'(queueDepth));
  assign notEmpty = (count != '0);
  assign doPush   = push && notFull;
  assign doPop    = pop && notEmpty;

  assign headOpcode  = opcodeMem[rdPtr];
  assign headOperand = operandMem[rdPtr];

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge phi2) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge phi2) begin
    if (doPush) begin
      opcodeMem[wrPtr]  <= pushOpcode;
      operandMem[wrPtr] <= pushOperand;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetchPredecode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// progData must answer progAddr in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "mini6502_settings.svh"

module fetchPredecode
  import mini6502Pkg::*;
(
  input  logic        phi2,
  input  logic        rst,
  input  logic [7:0]  progData,
  output logic [15:0] progAddr,
  output logic        sync,
  input  logic        notFull,
  output logic        push,
  output opcodeT      pushOpcode,
  output logic [7:0]  pushOperand
);

  fetchStateT  state;
  logic [15:0] pc;
  opcodeT      heldOpcode;
  opcodeT      decoded;
  logic        twoByte;

  // illegal bytes collapse to NOP here
  always_comb begin
    case (progData)
      LDA_IMM, LDX_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM,
      TAX, INX, CLC, SEC, STA_ZP, STX_ZP, NOP: begin
        decoded = opcodeT'(progData);
      end
      default: begin
        decoded = NOP;
      end
    endcase
  end

  // length predecode: immediate and zero page carry an operand
  always_comb begin
    case (decoded)
      LDA_IMM, LDX_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM,
      STA_ZP, STX_ZP: begin
        twoByte = 1'b1;
      end
      default: begin
        twoByte = 1'b0;
      end
    endcase
  end

  assign progAddr = pc;
  assign sync     = (state == FETCH_OPCODE) && notFull;

  // one-byte ops go out on the opcode edge, the others on the operand edge
  assign push = notFull &&
                (((state == FETCH_OPCODE) && !twoByte) || (state == FETCH_OPERAND));
  assign pushOpcode  = (state == FETCH_OPERAND) ? heldOpcode : decoded;
  assign pushOperand = (state == FETCH_OPERAND) ? progData : 8'h00;

  always_ff @(posedge phi2) begin
    if (rst) begin
      state <= FETCH_OPCODE;
      pc    <= `RESET_PC;
    end else begin
      case (state)
        FETCH_OPCODE: begin
          if (!notFull) begin
            state <= HOLD;
          end else begin
            pc <= pc + 16'd1;
            if (twoByte) begin
              state <= FETCH_OPERAND;
            end
          end
        end
        FETCH_OPERAND: begin
          // opcode stays latched until the queue takes the pair
          if (notFull) begin
            pc    <= pc + 16'd1;
            state <= FETCH_OPCODE;
          end
        end
        HOLD: begin
          if (notFull) begin
            state <= FETCH_OPCODE;
          end
        end
        default: begin
          state <= FETCH_OPCODE;
        end
      endcase
    end
  end

  always_ff @(posedge phi2) begin
    if ((state == FETCH_OPCODE) && notFull) begin
      heldOpcode <= decoded;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mini6502Pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode subset uses real 6502 encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mini6502Pkg;

  // supported opcodes, anything else runs as NOP
  typedef enum logic [7:0] {
    LDA_IMM = 8'hA9,
    LDX_IMM = 8'hA2,
    ADC_IMM = 8'h69,
    AND_IMM = 8'h29,
    ORA_IMM = 8'h09,
    EOR_IMM = 8'h49,
    TAX     = 8'hAA,
    INX     = 8'hE8,
    CLC     = 8'h18,
    SEC     = 8'h38,
    STA_ZP  = 8'h85,
    STX_ZP  = 8'h86,
    NOP     = 8'hEA
  } opcodeT;

  // fetch FSM
  typedef enum logic [1:0] {
    FETCH_OPCODE  = 2'd0,
    FETCH_OPERAND = 2'd1,
    HOLD          = 2'd2
  } fetchStateT;

  // P register layout
  localparam int carryBit     = 0;
  localparam int zeroBit      = 1;
  localparam int alwaysOneBit = 5;
  localparam int overflowBit  = 6;
  localparam int negativeBit  = 7;

endpackage

`default_nettype wire

//--- include/mini6502_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RESET_PC is the first fetch address out of reset
// QUEUE_DEPTH must be a power of two, 2 or more
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MINI6502_SETTINGS_SVH
`define MINI6502_SETTINGS_SVH

// program start, fetch begins here after rst
`define RESET_PC 16'h0200

// instruction queue entries
// pointers wrap by overflow, so keep this a power of two
`define QUEUE_DEPTH 4

`endif
